// ==== rtl/imager_consts.svh ====
`ifndef IMAGER_CONSTS_SVH
`define IMAGER_CONSTS_SVH

// Data path widths.
`define PIXEL_WIDTH 10
`define DATA_WIDTH 32
`define DIM_WIDTH 12

// Terminal addresses on the di bus.
`define TERM_IMAGER 16'h0010
`define TERM_CAPTURE 16'h0020

// Imager terminal registers.
`define REG_CTRL 8'h00
`define REG_NUM_ROWS 8'h01
`define REG_NUM_COLS 8'h02
`define REG_CONST_VALUE 8'h03
`define REG_CAPTURE 8'h04

// Capture terminal registers.
`define CAP_REG_DATA 8'h00
`define CAP_REG_DTYPE 8'h01
`define CAP_REG_STATUS 8'h02

// Frame timing and capture sizing.
`define H_BLANK 4
`define V_BLANK 16
`define CAPTURE_DEPTH 64

`endif

// ==== rtl/imager_pkg.sv ====
`include "imager_consts.svh"

package imager_pkg;

   typedef struct packed {
      logic [15:0]             term_addr;
      logic [7:0]              reg_addr;
      logic                    write;
      logic                    read;
      logic [`DATA_WIDTH-1:0]  datai;
   } di_req_t;

   typedef struct packed {
      logic [`DATA_WIDTH-1:0]  datao;
      logic                    read_rdy;
      logic [15:0]             transfer_status;
   } di_rsp_t;

   typedef enum logic [3:0] {
      DTYPE_FRAME_START = 4'h0,
      DTYPE_PIXEL       = 4'h1,
      DTYPE_PIXEL32     = 4'h2,
      DTYPE_FRAME_END   = 4'h3
   } dtype_t;

   typedef struct packed {
      logic                    dv;
      dtype_t                  dtype;
      logic [`DATA_WIDTH-1:0]  data;
   } stream_t;

   typedef enum logic {PAT_RAMP, PAT_CONST} pattern_t;
   typedef enum logic {SEL_RAW, SEL_PACKED} stream_sel_t;

   typedef struct packed {
      logic                     enable;
      pattern_t                 pattern;
      stream_sel_t              stream_sel;
      logic [`DIM_WIDTH-1:0]    num_rows;
      logic [`DIM_WIDTH-1:0]    num_cols;
      logic [`PIXEL_WIDTH-1:0]  const_value;
   } imager_cfg_t;

   typedef struct packed {
      logic                                 busy;
      logic                                 done;
      logic                                 overflow;
      logic [$clog2(`CAPTURE_DEPTH):0]      count;
   } cap_status_t;

   typedef enum logic [1:0] {PI_IDLE, PI_HBLANK, PI_LINE, PI_VBLANK} pi_state_t;
   typedef enum logic [1:0] {CAP_IDLE, CAP_WAIT, CAP_RUN, CAP_DONE} cap_state_t;

endpackage

// ==== rtl/imager_terminal.sv ====
`include "imager_consts.svh"

module imager_terminal import imager_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  di_req_t      di_req,
   output di_rsp_t      di_rsp,
   output imager_cfg_t  cfg,
   output logic         capture_arm,
   output logic         capture_pop,
   input  stream_t      head,
   input  cap_status_t  status
);

   logic                    imager_sel;
   logic                    cap_sel;
   logic                    imager_wr;
   logic [`DATA_WIDTH-1:0]  status_word;
   logic [`DATA_WIDTH-1:0]  imager_rdata;
   logic [`DATA_WIDTH-1:0]  cap_rdata;

   assign imager_sel = di_req.term_addr == `TERM_IMAGER;
   assign cap_sel    = di_req.term_addr == `TERM_CAPTURE;
   assign imager_wr  = imager_sel && di_req.write;

   assign capture_arm = imager_wr && di_req.reg_addr == `REG_CAPTURE;
   assign capture_pop = cap_sel && di_req.read && di_req.reg_addr == `CAP_REG_DATA;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         cfg <= '0;
      end else if (imager_wr) begin
         case (di_req.reg_addr)
            `REG_CTRL: begin
               cfg.enable     <= di_req.datai[0];
               cfg.pattern    <= pattern_t'(di_req.datai[1]);
               cfg.stream_sel <= stream_sel_t'(di_req.datai[2]);
            end
            `REG_NUM_ROWS:    cfg.num_rows    <= di_req.datai[`DIM_WIDTH-1:0];
            `REG_NUM_COLS:    cfg.num_cols    <= di_req.datai[`DIM_WIDTH-1:0];
            `REG_CONST_VALUE: cfg.const_value <= di_req.datai[`PIXEL_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // ##########################################################
   // Read-back
   // ##########################################################

   // Status layout: busy, done, overflow in bits 2..0, count from bit 16.
   always_comb begin
      status_word = '0;
      status_word[2:0] = {status.overflow, status.done, status.busy};
      status_word[16 +: $bits(status.count)] = status.count;
   end

   always_comb begin
      imager_rdata = '0;
      case (di_req.reg_addr)
         `REG_CTRL:        imager_rdata[2:0] = {cfg.stream_sel, cfg.pattern, cfg.enable};
         `REG_NUM_ROWS:    imager_rdata[`DIM_WIDTH-1:0] = cfg.num_rows;
         `REG_NUM_COLS:    imager_rdata[`DIM_WIDTH-1:0] = cfg.num_cols;
         `REG_CONST_VALUE: imager_rdata[`PIXEL_WIDTH-1:0] = cfg.const_value;
         `REG_CAPTURE:     imager_rdata = status_word;
         default: ;
      endcase
   end

   always_comb begin
      cap_rdata = '0;
      case (di_req.reg_addr)
         `CAP_REG_DATA:   cap_rdata = head.data;
         `CAP_REG_DTYPE:  cap_rdata[$bits(dtype_t)-1:0] = head.dtype;
         `CAP_REG_STATUS: cap_rdata = status_word;
         default: ;
      endcase
   end

   // Terminal priority; anything not decoded answers with status 1.
   always_comb begin
      if (imager_sel) begin
         di_rsp.datao           = imager_rdata;
         di_rsp.read_rdy        = 1'b1;
         di_rsp.transfer_status = 16'd0;
      end else if (cap_sel) begin
         di_rsp.datao           = cap_rdata;
         di_rsp.read_rdy        = head.dv;
         di_rsp.transfer_status = 16'd0;
      end else begin
         di_rsp.datao           = '0;
         di_rsp.read_rdy        = 1'b1;
         di_rsp.transfer_status = 16'd1;
      end
   end

endmodule

// ==== rtl/pattern_imager.sv ====
`include "imager_consts.svh"

module pattern_imager import imager_pkg::*; (
   input  logic                     clk,
   input  logic                     resetb,
   input  imager_cfg_t              cfg,
   output logic                     fv,
   output logic                     lv,
   output logic [`PIXEL_WIDTH-1:0]  pix
);

   localparam int BLANK_W = $clog2(`V_BLANK + 1);

   pi_state_t                state;
   logic [`DIM_WIDTH-1:0]    row;
   logic [`DIM_WIDTH-1:0]    col;
   logic [BLANK_W-1:0]       blank;
   logic [`PIXEL_WIDTH-1:0]  index;
   logic                     start_ok;

   assign start_ok = cfg.enable && cfg.num_rows != '0 && cfg.num_cols != '0;

   // A frame opens with one line blank while fv is already high.
   assign lv  = state == PI_LINE;
   assign pix = (cfg.pattern == PAT_CONST) ? cfg.const_value : index;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= PI_IDLE;
         fv    <= 1'b0;
         row   <= '0;
         col   <= '0;
         blank <= '0;
         index <= '0;
      end else begin
         case (state)
            PI_IDLE: begin
               if (start_ok) begin
                  state <= PI_HBLANK;
                  fv    <= 1'b1;
                  row   <= '0;
                  blank <= '0;
                  index <= '0;
               end
            end
            PI_HBLANK: begin
               blank <= blank + 1'b1;
               if (blank == BLANK_W'(`H_BLANK - 1)) begin
                  state <= PI_LINE;
                  col   <= '0;
               end
            end
            PI_LINE: begin
               col   <= col + 1'b1;
               index <= index + 1'b1;
               if (col == cfg.num_cols - 1'b1) begin
                  blank <= '0;
                  if (row == cfg.num_rows - 1'b1) begin
                     state <= PI_VBLANK;
                     fv    <= 1'b0;
                  end else begin
                     row   <= row + 1'b1;
                     state <= PI_HBLANK;
                  end
               end
            end
            default: begin
               blank <= blank + 1'b1;
               if (blank == BLANK_W'(`V_BLANK - 1)) begin
                  blank <= '0;
                  row   <= '0;
                  index <= '0;
                  fv    <= start_ok;
                  state <= start_ok ? PI_HBLANK : PI_IDLE;
               end
            end
         endcase
      end
   end

   lv_inside_fv: assert property (@(posedge clk) disable iff (!resetb) lv |-> fv);

endmodule

// ==== rtl/imager_rx.sv ====
`include "imager_consts.svh"

module imager_rx import imager_pkg::*; (
   input  logic                     clk,
   input  logic                     resetb,
   input  imager_cfg_t              cfg,
   input  logic                     fv,
   input  logic                     lv,
   input  logic [`PIXEL_WIDTH-1:0]  pix,
   output stream_t                  raw_stream
);

   logic                    fv_q;
   logic                    lv_q;
   logic                    fv_rise;
   logic                    fv_fall;
   logic                    lv_fall;
   logic [`DIM_WIDTH-1:0]   col_cnt;
   logic [`DIM_WIDTH-1:0]   row_cnt;
   logic [`DIM_WIDTH-1:0]   line_cols;
   logic [`DIM_WIDTH-1:0]   rows_done;
   logic [`DIM_WIDTH-1:0]   cols_done;
   logic                    in_frame;
   logic                    out_dv;
   dtype_t                  out_dtype;
   logic [`DATA_WIDTH-1:0]  out_data;

   assign fv_rise = fv && !fv_q;
   assign fv_fall = !fv && fv_q;
   assign lv_fall = !lv && lv_q;

   // The last line usually ends on the same edge as the frame.
   assign rows_done = row_cnt + `DIM_WIDTH'(lv_fall);
   assign cols_done = lv_fall ? col_cnt : line_cols;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         fv_q      <= 1'b0;
         lv_q      <= 1'b0;
         col_cnt   <= '0;
         row_cnt   <= '0;
         line_cols <= '0;
         out_dv    <= 1'b0;
      end else begin
         fv_q   <= fv;
         lv_q   <= lv;
         out_dv <= fv_rise || (fv && lv) || fv_fall;
         if (fv_rise) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            line_cols <= '0;
         end else begin
            if (fv && lv) begin
               col_cnt <= lv_q ? col_cnt + 1'b1 : `DIM_WIDTH'(1);
            end
            if (lv_fall) begin
               row_cnt   <= row_cnt + 1'b1;
               line_cols <= col_cnt;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fv_rise) begin
         out_dtype <= DTYPE_FRAME_START;
         out_data  <= {16'(cfg.num_rows), 16'(cfg.num_cols)};
      end else if (fv && lv) begin
         out_dtype <= DTYPE_PIXEL;
         out_data  <= `DATA_WIDTH'(pix);
      end else begin
         out_dtype <= DTYPE_FRAME_END;
         out_data  <= {16'(rows_done), 16'(cols_done)};
      end
   end

   assign raw_stream = '{dv: out_dv, dtype: out_dtype, data: out_data};

   // Tracks the emitted stream, not the input framing.
   always_ff @(posedge clk) begin
      if (!resetb) begin
         in_frame <= 1'b0;
      end else if (raw_stream.dv) begin
         if (raw_stream.dtype == DTYPE_FRAME_START) begin
            in_frame <= 1'b1;
         end else if (raw_stream.dtype == DTYPE_FRAME_END) begin
            in_frame <= 1'b0;
         end
      end
   end

   end_after_start: assert property (@(posedge clk) disable iff (!resetb)
      raw_stream.dv && raw_stream.dtype == DTYPE_FRAME_END |-> in_frame);

endmodule

// ==== rtl/raw_pack32.sv ====
`include "imager_consts.svh"

module raw_pack32 import imager_pkg::*; (
   input  logic     clk,
   input  logic     resetb,
   input  stream_t  raw_stream,
   output stream_t  packed_stream
);

   logic                     phase;
   logic                     is_pix;
   logic [`PIXEL_WIDTH-1:0]  first_pix;
   logic                     pk_dv;
   dtype_t                   pk_dtype;
   logic [`DATA_WIDTH-1:0]   pk_data;

   assign is_pix = raw_stream.dv && raw_stream.dtype == DTYPE_PIXEL;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         phase <= 1'b0;
         pk_dv <= 1'b0;
      end else begin
         // Even pixels are held back until their partner arrives.
         pk_dv <= raw_stream.dv && (raw_stream.dtype != DTYPE_PIXEL || phase);
         if (raw_stream.dv && raw_stream.dtype == DTYPE_FRAME_START) begin
            phase <= 1'b0;
         end else if (is_pix) begin
            phase <= !phase;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (is_pix && !phase) begin
         first_pix <= raw_stream.data[`PIXEL_WIDTH-1:0];
      end
      if (is_pix) begin
         pk_dtype <= DTYPE_PIXEL32;
         pk_data  <= {16'(raw_stream.data[`PIXEL_WIDTH-1:0]), 16'(first_pix)};
      end else begin
         pk_dtype <= raw_stream.dtype;
         pk_data  <= raw_stream.data;
      end
   end

   assign packed_stream = '{dv: pk_dv, dtype: pk_dtype, data: pk_data};

endmodule

// ==== rtl/stream_capture.sv ====
`include "imager_consts.svh"

module stream_capture import imager_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  imager_cfg_t  cfg,
   input  stream_t      raw_stream,
   input  stream_t      packed_stream,
   input  logic         capture_arm,
   input  logic         capture_pop,
   output stream_t      head,
   output cap_status_t  status
);

   localparam int DEPTH = `CAPTURE_DEPTH;
   localparam int AW = $clog2(DEPTH);

   stream_t                 sel;
   cap_state_t              state;
   logic [`DATA_WIDTH-1:0]  mem_data [DEPTH];
   dtype_t                  mem_dtype [DEPTH];
   logic [AW:0]             wr_ptr;
   logic [AW:0]             rd_ptr;
   logic [AW:0]             count;
   logic                    overflow;
   logic                    full;
   logic                    empty;
   logic                    store;
   logic                    push;
   logic                    pop;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         sel <= '0;
      end else begin
         sel <= (cfg.stream_sel == SEL_PACKED) ? packed_stream : raw_stream;
      end
   end

   assign count = wr_ptr - rd_ptr;
   assign full  = count == (AW + 1)'(DEPTH);
   assign empty = count == '0;

   // Storing starts at a frame start and runs through the frame end.
   assign store = sel.dv &&
                  ((state == CAP_WAIT && sel.dtype == DTYPE_FRAME_START) || state == CAP_RUN);
   assign push  = store && !full;
   assign pop   = capture_pop && !empty;

   // ##########################################################
   // Capture FSM and pointers
   // ##########################################################

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state    <= CAP_IDLE;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end else if (capture_arm) begin
         state    <= CAP_WAIT;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (store && full) begin
            overflow <= 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case (state)
            CAP_WAIT: if (store) state <= CAP_RUN;
            CAP_RUN:  if (sel.dv && sel.dtype == DTYPE_FRAME_END) state <= CAP_DONE;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_data[wr_ptr[AW-1:0]]  <= sel.data;
         mem_dtype[wr_ptr[AW-1:0]] <= sel.dtype;
      end
   end

   assign head = '{dv: !empty,
                   dtype: mem_dtype[rd_ptr[AW-1:0]],
                   data: mem_data[rd_ptr[AW-1:0]]};

   assign status = '{busy: state == CAP_WAIT || state == CAP_RUN,
                     done: state == CAP_DONE,
                     overflow: overflow,
                     count: count};

   no_pop_when_empty: assert property (@(posedge clk) disable iff (!resetb)
      capture_pop |-> !empty);

endmodule

// ==== rtl/imager_top.sv ====
`include "imager_consts.svh"

module imager_top import imager_pkg::*; (
   input  logic     clk,
   input  logic     resetb,
   input  di_req_t  di_req,
   output di_rsp_t  di_rsp
);

   imager_cfg_t              cfg;
   logic                     capture_arm;
   logic                     capture_pop;
   stream_t                  head;
   cap_status_t              status;
   logic                     fv;
   logic                     lv;
   logic [`PIXEL_WIDTH-1:0]  pix;
   stream_t                  raw_stream;
   stream_t                  packed_stream;

   imager_terminal u_terminal (
      .clk         (clk),
      .resetb      (resetb),
      .di_req      (di_req),
      .di_rsp      (di_rsp),
      .cfg         (cfg),
      .capture_arm (capture_arm),
      .capture_pop (capture_pop),
      .head        (head),
      .status      (status)
   );

   pattern_imager u_imager (
      .clk    (clk),
      .resetb (resetb),
      .cfg    (cfg),
      .fv     (fv),
      .lv     (lv),
      .pix    (pix)
   );

   imager_rx u_rx (
      .clk        (clk),
      .resetb     (resetb),
      .cfg        (cfg),
      .fv         (fv),
      .lv         (lv),
      .pix        (pix),
      .raw_stream (raw_stream)
   );

   raw_pack32 u_pack (
      .clk           (clk),
      .resetb        (resetb),
      .raw_stream    (raw_stream),
      .packed_stream (packed_stream)
   );

   stream_capture u_capture (
      .clk           (clk),
      .resetb        (resetb),
      .cfg           (cfg),
      .raw_stream    (raw_stream),
      .packed_stream (packed_stream),
      .capture_arm   (capture_arm),
      .capture_pop   (capture_pop),
      .head          (head),
      .status        (status)
   );

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
   output logic clk,
   output logic resetb
);

   timeunit 1ns;
   timeprecision 100ps;

   // 20 ns period.
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      resetb = 1'b0;
      repeat (16) @(posedge clk);
      resetb <= 1'b1;
   end

endmodule

// ==== tests/imager_tb.sv ====
`include "imager_consts.svh"

module imager_tb import imager_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   // Several times the longest test, an 8 by 10 frame and its read-back.
   localparam int TIMEOUT_CYCLES = 20000;
   localparam logic [31:0] SEED = 32'hbfda731f;

   logic         clk;
   logic         resetb;
   di_req_t      di_req;
   di_rsp_t      di_rsp;

   int           errors = 0;
   int           checks = 0;
   int           cycles;
   dtype_t       exp_dtype [$];
   logic [31:0]  exp_data [$];

   tb_clock u_clock (
      .clk    (clk),
      .resetb (resetb)
   );

   imager_top dut (
      .clk    (clk),
      .resetb (resetb),
      .di_req (di_req),
      .di_rsp (di_rsp)
   );

   // ##########################################################
   // Bus access and checking helpers
   // ##########################################################

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic reg_write(input logic [15:0] term, input logic [7:0] addr,
                            input logic [31:0] data);
      @(posedge clk);
      di_req <= '{term_addr: term, reg_addr: addr, write: 1'b1, read: 1'b0, datai: data};
      @(posedge clk);
      di_req <= '0;
   endtask

   // Response is combinational, so it is sampled mid-cycle.
   task automatic reg_read(input logic [15:0] term, input logic [7:0] addr,
                           output di_rsp_t rsp);
      @(posedge clk);
      di_req <= '{term_addr: term, reg_addr: addr, write: 1'b0, read: 1'b1, datai: '0};
      @(negedge clk);
      rsp = di_rsp;
      @(posedge clk);
      di_req <= '0;
   endtask

   task automatic wait_capture_done(output di_rsp_t rsp);
      do begin
         reg_read(`TERM_CAPTURE, `CAP_REG_STATUS, rsp);
      end while (!rsp.datao[1]);
   endtask

   function automatic logic [31:0] ctrl_word(input logic en, input logic pat,
                                             input logic sel);
      return {29'd0, sel, pat, en};
   endfunction

   // Expected stream: header, pixels in raster order, trailer with the same sizes.
   task automatic build_expected(input int rows, input int cols, input logic pack_sel,
                                 input logic use_const, input logic [9:0] cval);
      logic [31:0] dims;
      logic [9:0]  pix;
      logic [9:0]  prev;
      dims = {16'(rows), 16'(cols)};
      prev = '0;
      exp_dtype.delete();
      exp_data.delete();
      exp_dtype.push_back(DTYPE_FRAME_START);
      exp_data.push_back(dims);
      for (int i = 0; i < rows * cols; i++) begin
         pix = use_const ? cval : 10'(i);
         if (!pack_sel) begin
            exp_dtype.push_back(DTYPE_PIXEL);
            exp_data.push_back(32'(pix));
         end else if (i % 2 == 1) begin
            exp_dtype.push_back(DTYPE_PIXEL32);
            exp_data.push_back({16'(pix), 16'(prev)});
         end
         prev = pix;
      end
      exp_dtype.push_back(DTYPE_FRAME_END);
      exp_data.push_back(dims);
   endtask

   task automatic read_capture(input int n);
      di_rsp_t rsp;
      for (int i = 0; i < n; i++) begin
         reg_read(`TERM_CAPTURE, `CAP_REG_DTYPE, rsp);
         check_value("capture dtype", rsp.datao, 32'(exp_dtype[i]));
         reg_read(`TERM_CAPTURE, `CAP_REG_DATA, rsp);
         check_value("capture read_rdy", 32'(rsp.read_rdy), 32'd1);
         check_value("capture data", rsp.datao, exp_data[i]);
      end
      reg_read(`TERM_CAPTURE, `CAP_REG_STATUS, rsp);
      check_value("read_rdy after drain", 32'(rsp.read_rdy), 32'd0);
      check_value("count after drain", 32'(rsp.datao[22:16]), 32'd0);
   endtask

   // The imager is disabled right after done, while it still sits in frame blanking.
   task automatic capture_frame(input int rows, input int cols, input logic pack_sel,
                                input logic use_const, input logic [9:0] cval);
      di_rsp_t rsp;
      int      stored;
      logic    ovf;
      build_expected(rows, cols, pack_sel, use_const, cval);
      reg_write(`TERM_IMAGER, `REG_NUM_ROWS, 32'(rows));
      reg_write(`TERM_IMAGER, `REG_NUM_COLS, 32'(cols));
      reg_write(`TERM_IMAGER, `REG_CONST_VALUE, 32'(cval));
      reg_write(`TERM_IMAGER, `REG_CAPTURE, 32'd0);
      reg_write(`TERM_IMAGER, `REG_CTRL, ctrl_word(1'b1, use_const, pack_sel));
      wait_capture_done(rsp);
      reg_write(`TERM_IMAGER, `REG_CTRL, ctrl_word(1'b0, use_const, pack_sel));
      ovf = exp_data.size() > `CAPTURE_DEPTH;
      stored = ovf ? `CAPTURE_DEPTH : exp_data.size();
      check_value("status flags", 32'(rsp.datao[2:0]), {29'd0, ovf, 2'b10});
      check_value("status count", 32'(rsp.datao[22:16]), 32'(stored));
      read_capture(stored);
   endtask

   // ##########################################################
   // Directed tests
   // ##########################################################

   task automatic reset_readback();
      di_rsp_t rsp;
      reg_read(`TERM_IMAGER, `REG_CTRL, rsp);
      check_value("ctrl after reset", rsp.datao, 32'd0);
      check_value("imager read_rdy", 32'(rsp.read_rdy), 32'd1);
      check_value("imager transfer_status", 32'(rsp.transfer_status), 32'd0);
      reg_write(`TERM_IMAGER, `REG_NUM_ROWS, 32'h0000_0a5c);
      reg_write(`TERM_IMAGER, `REG_NUM_COLS, 32'h0000_0123);
      reg_write(`TERM_IMAGER, `REG_CONST_VALUE, 32'h0000_02b7);
      reg_read(`TERM_IMAGER, `REG_NUM_ROWS, rsp);
      check_value("num_rows", rsp.datao, 32'h0000_0a5c);
      reg_read(`TERM_IMAGER, `REG_NUM_COLS, rsp);
      check_value("num_cols", rsp.datao, 32'h0000_0123);
      reg_read(`TERM_IMAGER, `REG_CONST_VALUE, rsp);
      check_value("const_value", rsp.datao, 32'h0000_02b7);
      reg_read(`TERM_IMAGER, 8'h3c, rsp);
      check_value("unknown register", rsp.datao, 32'd0);
   endtask

   task automatic unknown_terminal();
      di_rsp_t rsp;
      reg_read(16'h0055, `REG_CTRL, rsp);
      check_value("unknown terminal datao", rsp.datao, 32'd0);
      check_value("unknown terminal read_rdy", 32'(rsp.read_rdy), 32'd1);
      check_value("unknown terminal transfer_status", 32'(rsp.transfer_status), 32'd1);
      reg_read(`TERM_CAPTURE, `CAP_REG_STATUS, rsp);
      check_value("empty capture read_rdy", 32'(rsp.read_rdy), 32'd0);
      check_value("capture transfer_status", 32'(rsp.transfer_status), 32'd0);
   endtask

   task automatic raw_ramp_capture();
      capture_frame(3, 4, 1'b0, 1'b0, 10'd0);
   endtask

   task automatic packed_capture();
      capture_frame(3, 4, 1'b1, 1'b0, 10'd0);
   endtask

   task automatic const_pattern_capture();
      logic [9:0] cval;
      cval = 10'($urandom());
      capture_frame(2, 6, 1'b0, 1'b1, cval);
   endtask

   // 82 words against a 64-deep buffer.
   task automatic overflow_capture();
      capture_frame(8, 10, 1'b0, 1'b0, 10'd0);
   endtask

   initial begin
      di_req = '0;
      void'($urandom(SEED));
      while (resetb !== 1'b1) @(posedge clk);
      reset_readback();
      unknown_terminal();
      raw_ramp_capture();
      packed_capture();
      const_pattern_capture();
      overflow_capture();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks run: %0d, errors: %0d", checks, errors + 1);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== imager_top.f ====
+incdir+rtl
rtl/imager_pkg.sv
rtl/imager_terminal.sv
rtl/pattern_imager.sv
rtl/imager_rx.sv
rtl/raw_pack32.sv
rtl/stream_capture.sv
rtl/imager_top.sv
tests/tb_clock.sv
tests/imager_tb.sv

// ==== Makefile ====
TOP = imager_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f imager_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
